// ==== design/spi_ctrl_pkg.sv ====
/*
  Shared types and constants for the SPI peripheral control plane.
  Imported by every design block and by the testbench model.
*/
package spi_ctrl_pkg;

  // config word length, must match exactly for a load
  localparam int CFG_BITS = 8;
  // adc, dac, aux
  localparam int NUM_PERIPH = 3;
  // slow blinker count width
  localparam int BLINK_BITS = 5;
  // log2 of clk cycles per gray step, kept small for simulation
  localparam int LOG2DELAY = 4;
  // flops per synchronizer chain
  localparam int SYNC_STAGES = 2;
  // bit counter wide enough to saturate one past CFG_BITS
  localparam int CNT_BITS = $clog2(CFG_BITS + 2);

  // periph_sel encodings
  localparam logic [1:0] PSEL_NONE = 2'd0;
  localparam logic [1:0] PSEL_ADC = 2'd1;
  localparam logic [1:0] PSEL_DAC = 2'd2;
  localparam logic [1:0] PSEL_AUX = 2'd3;

  // host link pins, cs_n active low
  typedef struct packed {
    logic sclk;
    logic cs_n;
    logic mosi;
    logic special;
  } host_pins_t;

  // one outgoing peripheral port
  typedef struct packed {
    logic sclk;
    logic cs_n;
    logic mosi;
  } periph_spi_t;

  // routing config, msb first here so led_val lands in bits 1:0
  typedef struct packed {
    logic [2:0] reserved;
    logic [1:0] periph_sel;
    logic       led_manual;
    logic [1:0] led_val;
  } route_cfg_t;

  // idle levels, also the synchronizer reset state
  localparam host_pins_t HOST_IDLE = '{sclk: 1'b0, cs_n: 1'b1, mosi: 1'b0, special: 1'b0};
  localparam periph_spi_t PERIPH_IDLE = '{sclk: 1'b0, cs_n: 1'b1, mosi: 1'b0};

endpackage

// ==== design/spi_pin_sync.sv ====
/*
  Resynchronizes host pins and peripheral miso lines into clk.
  Also produces registered one-cycle rising-edge pulses for sclk and cs_n.
*/
`timescale 1ns/1ps

module spi_pin_sync (
  input  logic                                clk,
  input  logic                                rst_n,
  input  spi_ctrl_pkg::host_pins_t            pins,
  input  logic [spi_ctrl_pkg::NUM_PERIPH-1:0] miso_in,
  output spi_ctrl_pkg::host_pins_t            sync_pins,
  output logic                                sclk_rise,
  output logic                                cs_rise,
  output logic [spi_ctrl_pkg::NUM_PERIPH-1:0] miso_sync
);

  import spi_ctrl_pkg::*;

  // synchronizer chains, stage 0 sees the raw pins
  host_pins_t            pin_stage  [SYNC_STAGES];
  logic [NUM_PERIPH-1:0] miso_stage [SYNC_STAGES];

  // one extra stage for edge detection
  logic sclk_prev;
  logic cs_prev;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      // idle levels so nothing looks like an edge out of reset
      for (int s = 0; s < SYNC_STAGES; s++)
      begin
        pin_stage[s]  <= HOST_IDLE;
        miso_stage[s] <= '0;
      end
      sclk_prev <= HOST_IDLE.sclk;
      cs_prev   <= HOST_IDLE.cs_n;
      sclk_rise <= 1'b0;
      cs_rise   <= 1'b0;
    end
    else
    begin
      pin_stage[0]  <= pins;
      miso_stage[0] <= miso_in;
      for (int s = 1; s < SYNC_STAGES; s++)
      begin
        pin_stage[s]  <= pin_stage[s-1];
        miso_stage[s] <= miso_stage[s-1];
      end
      sclk_prev <= sync_pins.sclk;
      cs_prev   <= sync_pins.cs_n;
      // pulses land one cycle after the synchronized level
      sclk_rise <= sync_pins.sclk & ~sclk_prev;
      cs_rise   <= sync_pins.cs_n & ~cs_prev;
    end
  end

  assign sync_pins = pin_stage[SYNC_STAGES-1];
  assign miso_sync = miso_stage[SYNC_STAGES-1];

endmodule

// ==== design/spi_route_latch.sv ====
/*
  Collects host config words and holds the routing configuration.
  A word loads only when exactly CFG_BITS sclk rises arrived with special low.
*/
`timescale 1ns/1ps

module spi_route_latch (
  input  logic                     clk,
  input  logic                     rst_n,
  input  spi_ctrl_pkg::host_pins_t sync_pins,
  input  logic                     sclk_rise,
  input  logic                     cs_rise,
  output spi_ctrl_pkg::route_cfg_t route_cfg
);

  import spi_ctrl_pkg::*;

  logic [CFG_BITS-1:0] shift_q;
  logic [CNT_BITS-1:0] bit_cnt;

  // a config bit arrives on an sclk rise while selected and not special
  logic cfg_bit;
  // the word just closed had the exact length
  logic word_ok;

  assign cfg_bit = sclk_rise && !sync_pins.cs_n && !sync_pins.special;
  assign word_ok = (bit_cnt == CNT_BITS'(CFG_BITS)) && !sync_pins.special;

  // msb-first shift register
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      shift_q <= '0;
    end
    else if (cfg_bit)
    begin
      shift_q <= {shift_q[CFG_BITS-2:0], sync_pins.mosi};
    end
  end

  // bit counter
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bit_cnt <= '0;
    end
    else if (cs_rise)
    begin
      // count restarts at the end of a word after the load decision below
      // stays at zero while cs_n is high since no bits shift then
      bit_cnt <= '0;
    end
    else if (cfg_bit && bit_cnt <= CNT_BITS'(CFG_BITS))
    begin
      // saturates at CFG_BITS+1 so a long word stays a mismatch
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // configuration register
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      // no port selected and blinker mode
      route_cfg <= '0;
    end
    else if (cs_rise && word_ok)
    begin
      route_cfg <= route_cfg_t'(shift_q);
    end
  end

endmodule

// ==== design/periph_router.sv ====
/*
  Routes synchronized host SPI traffic to the selected peripheral port.
  The selected port's miso returns to the host through an output register.
*/
`timescale 1ns/1ps

module periph_router (
  input  logic                                                  clk,
  input  logic                                                  rst_n,
  input  spi_ctrl_pkg::host_pins_t                              sync_pins,
  input  spi_ctrl_pkg::route_cfg_t                              route_cfg,
  input  logic [spi_ctrl_pkg::NUM_PERIPH-1:0]                   miso_sync,
  output spi_ctrl_pkg::periph_spi_t [spi_ctrl_pkg::NUM_PERIPH-1:0] periph,
  output logic                                                  spi_miso
);

  import spi_ctrl_pkg::*;

  // one-hot port enable, bit 0 adc, bit 1 dac, bit 2 aux
  logic [NUM_PERIPH-1:0] port_en;

  // host pins as they would appear on an active port
  periph_spi_t host_mirror;

  always_comb
  begin
    case (route_cfg.periph_sel)
      PSEL_NONE:
      begin
        port_en = '0;
      end
      PSEL_ADC:
      begin
        port_en = 3'b001;
      end
      PSEL_DAC:
      begin
        port_en = 3'b010;
      end
      PSEL_AUX:
      begin
        port_en = 3'b100;
      end
      default:
      begin
        port_en = '0;
      end
    endcase
  end

  assign host_mirror = '{
    sclk: sync_pins.sclk,
    cs_n: sync_pins.cs_n,
    mosi: sync_pins.mosi
  };

  // port output registers
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < NUM_PERIPH; i++)
      begin
        periph[i] <= PERIPH_IDLE;
      end
    end
    else
    begin
      for (int i = 0; i < NUM_PERIPH; i++)
      begin
        // special low is config traffic, it never leaves the fpga
        if (port_en[i] && sync_pins.special)
        begin
          periph[i] <= host_mirror;
        end
        else
        begin
          periph[i] <= PERIPH_IDLE;
        end
      end
    end
  end

  // miso return, enable is one-hot so the or is a select
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      spi_miso <= 1'b0;
    end
    else
    begin
      spi_miso <= |(miso_sync & port_en);
    end
  end

endmodule

// ==== design/led_blinker.sv ====
/*
  Drives the two LEDs, either a slow gray-code count or manual bits
  taken from the routing configuration.
*/
`timescale 1ns/1ps

module led_blinker (
  input  logic                     clk,
  input  logic                     rst_n,
  input  spi_ctrl_pkg::route_cfg_t route_cfg,
  output logic [1:0]               leds
);

  import spi_ctrl_pkg::*;

  // free-running divider, upper bits form the slow count
  logic [BLINK_BITS+LOG2DELAY-1:0] div_cnt;
  logic [BLINK_BITS-1:0]           slow_cnt;
  logic [1:0]                      led_gray;

  assign slow_cnt = div_cnt[BLINK_BITS+LOG2DELAY-1:LOG2DELAY];

  // 2-bit gray of the low slow bits
  // gives 00, 01, 11, 10 with one bit flip per step
  assign led_gray = {slow_cnt[1], slow_cnt[1] ^ slow_cnt[0]};

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      div_cnt <= '0;
      leds    <= 2'b00;
    end
    else
    begin
      div_cnt <= div_cnt + 1'b1;
      // manual bits show one cycle after the config changes
      if (route_cfg.led_manual)
      begin
        leds <= route_cfg.led_val;
      end
      else
      begin
        leds <= led_gray;
      end
    end
  end

endmodule

// ==== design/spi_periph_ctrl_top.sv ====
/*
  Top of the SPI control plane. The host loads a routing word over SPI,
  then its special-high traffic reaches the adc, dac or aux port.
*/
`timescale 1ns/1ps

module spi_periph_ctrl_top (
  input  logic                                                  clk,
  input  logic                                                  rst_n,
  input  spi_ctrl_pkg::host_pins_t                              host,
  output logic                                                  spi_miso,
  output spi_ctrl_pkg::periph_spi_t [spi_ctrl_pkg::NUM_PERIPH-1:0] periph,
  input  logic [spi_ctrl_pkg::NUM_PERIPH-1:0]                   periph_miso,
  output logic [1:0]                                            leds
);

  import spi_ctrl_pkg::*;

  // host pins in the clk domain
  host_pins_t sync_pins;
  // one-cycle edge pulses
  logic sclk_rise;
  logic cs_rise;
  // synchronized peripheral miso
  logic [NUM_PERIPH-1:0] miso_sync;
  // current routing word
  route_cfg_t route_cfg;

  spi_pin_sync u_pin_sync (
    .clk       (clk),
    .rst_n     (rst_n),
    .pins      (host),
    .miso_in   (periph_miso),
    .sync_pins (sync_pins),
    .sclk_rise (sclk_rise),
    .cs_rise   (cs_rise),
    .miso_sync (miso_sync)
  );

  // config words arrive with special low
  spi_route_latch u_route_latch (
    .clk       (clk),
    .rst_n     (rst_n),
    .sync_pins (sync_pins),
    .sclk_rise (sclk_rise),
    .cs_rise   (cs_rise),
    .route_cfg (route_cfg)
  );

  // data traffic with special high
  periph_router u_router (
    .clk       (clk),
    .rst_n     (rst_n),
    .sync_pins (sync_pins),
    .route_cfg (route_cfg),
    .miso_sync (miso_sync),
    .periph    (periph),
    .spi_miso  (spi_miso)
  );

  led_blinker u_blinker (
    .clk       (clk),
    .rst_n     (rst_n),
    .route_cfg (route_cfg),
    .leds      (leds)
  );

endmodule

// ==== dv/tb_spi_periph_ctrl.sv ====
/*
  Self-checking testbench for the SPI control plane top.
  Random config words and routed transfers, checked against a cycle model.
*/
`timescale 1ns/1ps

module tb_spi_periph_ctrl;

  import spi_ctrl_pkg::*;

  // clk cycles per sclk half period
  localparam int HALF = 4;
  localparam int NUM_WORDS = 40;
  localparam int XFERS_PER_SEL = 4;
  localparam int MAX_BITS = 12;
  // pin to port latency and miso to spi_miso latency
  localparam int PIPE = SYNC_STAGES + 1;
  // cs_n pin rise to route_cfg load
  localparam int LOAD_LAT = SYNC_STAGES + 2;
  localparam int HOLD_CYCLES = 1 << LOG2DELAY;
  localparam int BLINK_CYCLES = 6 * HOLD_CYCLES;
  // worst case length of one word plus its gap
  localparam int XFER_MAX = (2 * MAX_BITS + 3) * HALF + 8;
  localparam int PLANNED = 2 * NUM_WORDS * XFER_MAX
                         + 4 * (1 + XFERS_PER_SEL) * XFER_MAX + BLINK_CYCLES + 20;
  localparam int TIMEOUT = 2 * PLANNED;

  logic                         clk;
  logic                         rst_n;
  host_pins_t                   host;
  logic                         spi_miso;
  periph_spi_t [NUM_PERIPH-1:0] periph;
  logic [NUM_PERIPH-1:0]        periph_miso;
  logic [1:0]                   leds;

  integer     seed;
  int         cycles = 0;
  bit         mon_en;
  // expected route_cfg updated in the cycle the DUT loads it
  route_cfg_t cfg_model;

  // per-cycle history with index 0 as the current cycle
  host_pins_t            pin_hist  [PIPE+1];
  logic [NUM_PERIPH-1:0] miso_hist [PIPE+1];
  route_cfg_t            cfg_hist  [PIPE+1];

  spi_periph_ctrl_top uut (
    .clk         (clk),
    .rst_n       (rst_n),
    .host        (host),
    .spi_miso    (spi_miso),
    .periph      (periph),
    .periph_miso (periph_miso),
    .leds        (leds)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run();
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("FAIL %s expected %0h got %0h", name, expected, actual);
      abort_run();
    end
  endtask

  // hang guard
  always @(posedge clk)
  begin
    cycles++;
    if (cycles > TIMEOUT)
    begin
      $display("ERROR: run did not finish within %0d clk cycles", TIMEOUT);
      abort_run();
    end
  end

  // port i mirrors host pins only when selected and special is high
  function automatic periph_spi_t expected_port(int idx, route_cfg_t cfg, host_pins_t pins);
    periph_spi_t p;
    p = PERIPH_IDLE;
    if (cfg.periph_sel == 2'(idx + 1) && pins.special)
    begin
      p.sclk = pins.sclk;
      p.cs_n = pins.cs_n;
      p.mosi = pins.mosi;
    end
    return p;
  endfunction

  function automatic logic expected_miso(route_cfg_t cfg, logic [NUM_PERIPH-1:0] miso);
    if (cfg.periph_sel == PSEL_NONE)
    begin
      return 1'b0;
    end
    return miso[cfg.periph_sel - 1];
  endfunction

  // 00, 01, 11, 10 and around
  function automatic logic [1:0] next_gray(logic [1:0] g);
    case (g)
      2'b00: return 2'b01;
      2'b01: return 2'b11;
      2'b11: return 2'b10;
      default: return 2'b00;
    endcase
  endfunction

  // ports and spi_miso checked every cycle at the falling edge
  always @(negedge clk)
  begin
    for (int k = PIPE; k > 0; k--)
    begin
      pin_hist[k]  = pin_hist[k-1];
      miso_hist[k] = miso_hist[k-1];
      cfg_hist[k]  = cfg_hist[k-1];
    end
    pin_hist[0]  = host;
    miso_hist[0] = periph_miso;
    cfg_hist[0]  = cfg_model;
    if (mon_en)
    begin
      // router registers see last cycle's route_cfg
      for (int i = 0; i < NUM_PERIPH; i++)
      begin
        compare_value($sformatf("periph[%0d]", i),
                      expected_port(i, cfg_hist[1], pin_hist[PIPE]), periph[i]);
      end
      compare_value("spi_miso", expected_miso(cfg_hist[1], miso_hist[PIPE]), spi_miso);
    end
  end

  // inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
    periph_miso = NUM_PERIPH'($random(seed));
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  // bit-bang one word msb first and end with cs_n just raised
  task automatic send_word(input int nbits, input logic [15:0] data, input logic special);
    host.special = special;
    wait_cycles(HALF);
    host.cs_n = 1'b0;
    wait_cycles(HALF);
    for (int b = nbits - 1; b >= 0; b--)
    begin
      host.mosi = data[b];
      host.sclk = 1'b0;
      wait_cycles(HALF);
      host.sclk = 1'b1;
      wait_cycles(HALF);
    end
    host.sclk = 1'b0;
    host.mosi = 1'b0;
    wait_cycles(HALF);
    host.cs_n = 1'b1;
  endtask

  // only an exact-length special-low word loads
  task automatic load_config(input int nbits, input logic [15:0] data);
    send_word(nbits, data, 1'b0);
    wait_cycles(LOAD_LAT);
    if (nbits == CFG_BITS)
    begin
      cfg_model = route_cfg_t'(data[CFG_BITS-1:0]);
    end
    // six cycles after the cs_n rise
    wait_cycles(6 - LOAD_LAT);
    if (cfg_model.led_manual)
    begin
      compare_value("leds", cfg_model.led_val, leds);
    end
  endtask

  // special held through the cs_n rise and dropped after
  task automatic data_transfer(input int nbits, input logic [15:0] data);
    send_word(nbits, data, 1'b1);
    wait_cycles(6);
    host.special = 1'b0;
    wait_cycles(2);
  endtask

  initial
  begin
    int         len_sel;
    int         nbits;
    logic [1:0] prev_leds;
    int         hold_cnt;
    int         changes;
    bit         seen;

    seed = 32'h9592f226;
    mon_en = 1'b0;
    cfg_model = '0;
    rst_n = 1'b0;
    host = HOST_IDLE;
    periph_miso = '0;
    for (int k = 0; k <= PIPE; k++)
    begin
      pin_hist[k]  = HOST_IDLE;
      miso_hist[k] = '0;
      cfg_hist[k]  = '0;
    end
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    mon_en = 1'b1;

    // reset state
    wait_cycles(2);
    for (int i = 0; i < NUM_PERIPH; i++)
    begin
      compare_value($sformatf("periph[%0d]", i), PERIPH_IDLE, periph[i]);
    end
    compare_value("spi_miso", 1'b0, spi_miso);

    // random config words of 7, 8 or 9 bits with a probe after each
    for (int n = 0; n < NUM_WORDS; n++)
    begin
      len_sel = $random(seed) & 7;
      nbits = (len_sel == 0) ? CFG_BITS - 1 : (len_sel == 1) ? CFG_BITS + 1 : CFG_BITS;
      load_config(nbits, 16'($random(seed)));
      data_transfer(1 + ($random(seed) & 7), 16'($random(seed)));
    end

    // every periph_sel value in turn with led_manual clear
    for (int s = 0; s < 4; s++)
    begin
      // periph_sel sits at bits 4:3
      load_config(CFG_BITS, 16'(s << 3));
      for (int t = 0; t < XFERS_PER_SEL; t++)
      begin
        data_transfer(4 + ($random(seed) & 7), 16'($random(seed)));
      end
    end

    // blinker check with the first hold not measured
    prev_leds = leds;
    hold_cnt = 0;
    changes = 0;
    seen = 1'b0;
    for (int c = 0; c < BLINK_CYCLES; c++)
    begin
      next_cycle();
      hold_cnt++;
      if (leds !== prev_leds)
      begin
        compare_value("leds", next_gray(prev_leds), leds);
        if (seen)
        begin
          compare_value("leds hold cycles", HOLD_CYCLES, hold_cnt);
        end
        seen = 1'b1;
        hold_cnt = 0;
        prev_leds = leds;
        changes++;
      end
    end
    if (changes < 3)
    begin
      $display("ERROR: blinker leds changed only %0d times", changes);
      abort_run();
    end

    $display("Verification passed");
    $finish;
  end

endmodule

// ==== files.f ====
design/spi_ctrl_pkg.sv
design/spi_pin_sync.sv
design/spi_route_latch.sv
design/periph_router.sv
design/led_blinker.sv
design/spi_periph_ctrl_top.sv
dv/tb_spi_periph_ctrl.sv
